// File: files.f
+incdir+verification
design/gpr_pkg.sv
design/gpr_bank.sv
design/wb_arbiter.sv
design/load_scoreboard.sv
design/gpr_subsys_top.sv
verification/gpr_subsys_tb.sv

// File: verification/gpr_ref_model.svh
// Reference model state and functions for register contents, write arbitration and busy bits
`ifndef GPR_REF_MODEL_SVH
`define GPR_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Model state
//////////////////////////////////////////////////////////////////////
word_t      m_regs  [NUM_HARTS][32];   // Architectural contents per hart
bit         m_known [NUM_HARTS][32];   // Written since start of run
bit         m_busy  [NUM_HARTS][32];   // Load outstanding
gpr_write_t m_queue [$];               // Losing loads, oldest first

// Expected write for this cycle, by priority
function automatic gpr_commit_t model_grant(input gpr_write_t alu, input gpr_write_t ld);
    gpr_commit_t g;
    g = '0;
    if (alu.valid) begin
        g.wr  = alu;                   // ALU always wins
        g.src = SRC_ALU;
    end else if (m_queue.size() > 0) begin
        g.wr  = m_queue[0];            // Oldest waiting load
        g.src = SRC_LOAD;
    end else if (ld.valid) begin
        g.wr  = ld;
        g.src = SRC_LOAD;
    end
    return g;
endfunction

// Read value seen on a port, including same-cycle forwarding
function automatic word_t model_read(input hart_id_t h, input reg_addr_t a,
                                     input gpr_write_t alu, input gpr_write_t ld);
    gpr_commit_t g;
    g = model_grant(alu, ld);
    if (a == '0) begin
        return '0;
    end
    if (g.wr.valid && g.wr.hart == h && g.wr.addr == a) begin
        return g.wr.data;
    end
    return m_regs[h][a];
endfunction

// Data is defined for x0, a forwarded commit or a written register
function automatic bit model_known(input hart_id_t h, input reg_addr_t a,
                                   input gpr_write_t alu, input gpr_write_t ld);
    gpr_commit_t g;
    g = model_grant(alu, ld);
    return (a == '0) || (g.wr.valid && g.wr.hart == h && g.wr.addr == a) || m_known[h][a];
endfunction

function automatic logic model_busy(input hart_id_t h, input reg_addr_t a);
    return m_busy[h][a];
endfunction

function automatic logic model_full();
    return m_queue.size() == 2;
endfunction

// Advance by one clock edge with the inputs sampled before it
function automatic void model_step(input logic rst_s, input gpr_write_t alu,
                                   input gpr_write_t ld, input logic issue,
                                   input hart_id_t ih, input reg_addr_t ir);
    gpr_commit_t g;
    bit          was_full;
    bit          pop;
    bit          direct;
    if (rst_s) begin
        m_queue.delete();
        foreach (m_busy[h, r]) begin
            m_busy[h][r] = 1'b0;
        end
        return;
    end
    g        = model_grant(alu, ld);
    was_full = model_full();
    pop      = !alu.valid && (m_queue.size() > 0);
    direct   = !alu.valid && (m_queue.size() == 0) && ld.valid;
    if (g.wr.valid && g.wr.addr != '0) begin
        m_regs[g.wr.hart][g.wr.addr]  = g.wr.data;
        m_known[g.wr.hart][g.wr.addr] = 1'b1;
    end
    if (g.wr.valid && g.src == SRC_LOAD) begin
        m_busy[g.wr.hart][g.wr.addr] = 1'b0;   // Load result releases the register
    end
    if (issue && ir != '0) begin
        m_busy[ih][ir] = 1'b1;                 // Set overrides a same-cycle clear
    end
    if (pop) begin
        void'(m_queue.pop_front());
    end
    if (ld.valid && !direct && !was_full) begin
        m_queue.push_back(ld);                 // Dropped when presented while full
    end
endfunction

`endif

// File: verification/gpr_subsys_tb.sv
// Testbench for the register storage subsystem: clock, reset, stimulus, model checks, report
`timescale 1ns/1ps

module gpr_subsys_tb;

    import gpr_pkg::*;

    localparam int NUM_HARTS  = 4;
    localparam int CLK_PERIOD = 100;
    localparam int T1_CYCLES  = 2 * NUM_HARTS * 32;      // Fill then read back
    localparam int T2_CYCLES  = 6;
    localparam int T3_CYCLES  = 8;
    localparam int T4_CYCLES  = 10;
    localparam int T5_CYCLES  = 2000 + 8;                // Random plus drain
    localparam int STIM_CYCLES = 3 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    logic       clk;
    logic       rst;
    gpr_write_t alu_wr;
    gpr_write_t load_wr;
    logic       load_issue;
    hart_id_t   load_issue_hart;
    reg_addr_t  load_issue_rd;
    hart_id_t   rd_hart;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       rs1_busy;
    logic       rs2_busy;
    logic       load_full;

    int         check_count = 0;
    int         error_count = 0;
    int         test_errors_at_start;
    int         cycle_count = 0;
    bit         saw_full;                // load_full observed high
    gpr_write_t pend [$];                // Issued loads not yet returned

    `include "gpr_ref_model.svh"

    gpr_subsys_top #(
        .NUM_HARTS (NUM_HARTS)
    ) gpr_subsys_top_i (
        .clk (clk), .rst (rst), .alu_wr (alu_wr), .load_wr (load_wr),
        .load_issue (load_issue), .load_issue_hart (load_issue_hart),
        .load_issue_rd (load_issue_rd), .rd_hart (rd_hart),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .rs1_busy (rs1_busy), .rs2_busy (rs2_busy), .load_full (load_full)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_word(input word_t got, input word_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Sample 5 ns before each rising edge, step the model at the edge
    initial begin
        gpr_write_t s_alu;
        gpr_write_t s_ld;
        logic       s_rst;
        logic       s_issue;
        hart_id_t   s_ih;
        reg_addr_t  s_ir;
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 5);
            if (!rst) begin
                if (model_known(rd_hart, rs1_addr, alu_wr, load_wr)) begin
                    check_word(rs1_data, model_read(rd_hart, rs1_addr, alu_wr, load_wr),
                               "rs1_data");
                end
                if (model_known(rd_hart, rs2_addr, alu_wr, load_wr)) begin
                    check_word(rs2_data, model_read(rd_hart, rs2_addr, alu_wr, load_wr),
                               "rs2_data");
                end
                check_flag(rs1_busy, model_busy(rd_hart, rs1_addr), "rs1_busy");
                check_flag(rs2_busy, model_busy(rd_hart, rs2_addr), "rs2_busy");
                check_flag(load_full, model_full(), "load_full");
                if (load_full === 1'b1) begin
                    saw_full = 1'b1;
                end
            end
            s_rst   = rst;
            s_alu   = alu_wr;
            s_ld    = load_wr;
            s_issue = load_issue;
            s_ih    = load_issue_hart;
            s_ir    = load_issue_rd;
            @(posedge clk);
            model_step(s_rst, s_alu, s_ld, s_issue, s_ih, s_ir);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #10;                                 // Drive after the edge
    endtask

    task automatic clear_writes();
        alu_wr          = '0;
        load_wr         = '0;
        load_issue      = 1'b0;
        load_issue_hart = '0;
        load_issue_rd   = '0;
    endtask

    function automatic gpr_write_t make_wr(input int h, input int r, input word_t d);
        gpr_write_t w;
        w.valid = 1'b1;
        w.hart  = hart_id_t'(h);
        w.addr  = reg_addr_t'(r);
        w.data  = d;
        return w;
    endfunction

    task automatic set_read(input int h, input int r1, input int r2);
        rd_hart  = hart_id_t'(h);
        rs1_addr = reg_addr_t'(r1);
        rs2_addr = reg_addr_t'(r2);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            clear_writes();
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("Test %0d %s finished, %0d errors", num, name,
                 error_count - test_errors_at_start);
        test_errors_at_start = error_count;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    initial begin
        int h;
        int r;
        void'($urandom(32'h240eb0de));
        rst = 1'b1;
        clear_writes();
        set_read(0, 0, 0);
        test_errors_at_start = 0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        // 1. Pattern depends on hart and register, x0 written too
        for (int i = 0; i < NUM_HARTS * 32; i++) begin
            next_cycle();
            alu_wr = make_wr(i / 32, i % 32, {8'(i / 32), 8'(i % 32), 16'(i) ^ 16'hA5C3});
            set_read(i / 32, i % 32, 0);
        end
        for (int i = 0; i < NUM_HARTS * 32; i++) begin
            next_cycle();
            clear_writes();
            set_read(i / 32, i % 32, 31 - (i % 32));
        end
        finish_test(1, "write and read back");

        // 2. Forwarding to own hart only
        next_cycle();
        alu_wr = make_wr(1, 5, 32'hB1A5_0005);
        set_read(1, 5, 6);
        next_cycle();
        alu_wr = make_wr(2, 5, 32'hB2A5_0005);   // Same number, other hart
        set_read(1, 5, 5);
        next_cycle();
        clear_writes();
        load_wr = make_wr(3, 9, 32'hC3D0_0009);  // Direct load commit
        set_read(3, 9, 9);
        idle(1);
        set_read(2, 5, 5);
        idle(T2_CYCLES - 4);
        finish_test(2, "same-cycle bypass");

        // 3. Both writers at once, loads park then drain in order
        saw_full = 1'b0;
        next_cycle();
        alu_wr  = make_wr(0, 3, 32'hA100_0003);
        load_wr = make_wr(0, 3, 32'h1D01_0003);
        set_read(0, 3, 5);
        next_cycle();
        alu_wr  = make_wr(0, 4, 32'hA100_0004);
        load_wr = make_wr(0, 5, 32'h1D02_0005);
        idle(T3_CYCLES - 2);
        check_flag(saw_full, 1'b1, "load_full raised with two loads waiting");
        finish_test(3, "arbitration");

        // 4. Busy across queueing, then set winning over clear
        next_cycle();
        load_issue      = 1'b1;
        load_issue_hart = 2'd2;
        load_issue_rd   = 5'd7;
        set_read(2, 7, 8);
        next_cycle();
        clear_writes();
        alu_wr  = make_wr(2, 10, 32'hA200_000A);
        load_wr = make_wr(2, 7, 32'h1D20_0007);  // Loses, waits in queue
        next_cycle();
        clear_writes();
        alu_wr = make_wr(2, 11, 32'hA200_000B);
        idle(1);                                 // Queue drains, x7 released
        next_cycle();
        load_issue      = 1'b1;
        load_issue_hart = 2'd2;
        load_issue_rd   = 5'd8;
        next_cycle();
        load_wr    = make_wr(2, 8, 32'h1D21_0008);  // Clear and new set together
        load_issue = 1'b1;
        next_cycle();
        clear_writes();
        load_wr = make_wr(2, 8, 32'h1D22_0008);
        idle(T4_CYCLES - 7);
        finish_test(4, "scoreboard");

        // 5. Random traffic across all harts
        for (int i = 0; i < 2000; i++) begin
            next_cycle();
            clear_writes();
            if ($urandom_range(1, 0) == 1) begin
                alu_wr = make_wr($urandom_range(3, 0), $urandom_range(31, 0), $urandom());
            end
            if (pend.size() > 0 && !load_full && $urandom_range(2, 0) == 0) begin
                load_wr = pend.pop_front();
            end
            if (pend.size() < 6 && $urandom_range(3, 0) == 0) begin
                h = $urandom_range(3, 0);
                r = $urandom_range(7, 0);            // Narrow window for busy hits
                load_issue      = 1'b1;
                load_issue_hart = hart_id_t'(h);
                load_issue_rd   = reg_addr_t'(r);
                pend.push_back(make_wr(h, r, $urandom()));
            end
            set_read($urandom_range(3, 0), $urandom_range(7, 0), $urandom_range(31, 0));
        end
        idle(8);
        finish_test(5, "random mix");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: design/gpr_subsys_top.sv
// Register storage subsystem top, arbiter and scoreboard and register bank
`timescale 1ns/1ps

module gpr_subsys_top #(
    parameter int NUM_HARTS = 4                     // Must fit in HART_ID_W
) (
    input  logic                clk,
    input  logic                rst,
    // Writeback sources
    input  gpr_pkg::gpr_write_t alu_wr,
    input  gpr_pkg::gpr_write_t load_wr,
    // Load issue from the memory stage
    input  logic                load_issue,
    input  gpr_pkg::hart_id_t   load_issue_hart,
    input  gpr_pkg::reg_addr_t  load_issue_rd,
    // Decode read side
    input  gpr_pkg::hart_id_t   rd_hart,
    input  gpr_pkg::reg_addr_t  rs1_addr,
    input  gpr_pkg::reg_addr_t  rs2_addr,
    output gpr_pkg::word_t      rs1_data,
    output gpr_pkg::word_t      rs2_data,
    output logic                rs1_busy,
    output logic                rs2_busy,
    // Back pressure to the memory stage
    output logic                load_full
);

    import gpr_pkg::*;

    gpr_commit_t commit;    // Granted write, fans out to bank and scoreboard

    //////////////////////////////////////////////////////////////////////
    // Write port arbitration
    //////////////////////////////////////////////////////////////////////
    wb_arbiter wb_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .alu_wr    (alu_wr),
        .load_wr   (load_wr),
        .commit    (commit),
        .load_full (load_full)
    );

    //////////////////////////////////////////////////////////////////////
    // Storage and busy tracking
    //////////////////////////////////////////////////////////////////////
    gpr_bank #(
        .NUM_HARTS (NUM_HARTS)
    ) gpr_bank_i (
        .clk      (clk),
        .rst      (rst),
        .commit   (commit),
        .rd_hart  (rd_hart),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    load_scoreboard #(
        .NUM_HARTS (NUM_HARTS)
    ) load_scoreboard_i (
        .clk             (clk),
        .rst             (rst),
        .load_issue      (load_issue),
        .load_issue_hart (load_issue_hart),
        .load_issue_rd   (load_issue_rd),
        .commit          (commit),
        .rd_hart         (rd_hart),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rs1_busy        (rs1_busy),
        .rs2_busy        (rs2_busy)
    );

endmodule

// File: design/load_scoreboard.sv
// Per-hart busy bits for destination registers with a load outstanding
`timescale 1ns/1ps

module load_scoreboard #(
    parameter int NUM_HARTS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_issue,       // Load sent to memory
    input  gpr_pkg::hart_id_t    load_issue_hart,
    input  gpr_pkg::reg_addr_t   load_issue_rd,
    input  gpr_pkg::gpr_commit_t commit,           // Granted write from the arbiter
    input  gpr_pkg::hart_id_t    rd_hart,          // Decode side operands
    input  gpr_pkg::reg_addr_t   rs1_addr,
    input  gpr_pkg::reg_addr_t   rs2_addr,
    output logic                 rs1_busy,
    output logic                 rs2_busy
);

    import gpr_pkg::*;

    localparam int IDX_W = HART_ID_W + REG_ADDR_W;
    localparam int DEPTH = NUM_HARTS * REGS_PER_HART;

    logic [DEPTH-1:0]  busy;        // One bit per hart and register
    logic [IDX_W-1:0]  set_idx;
    logic [IDX_W-1:0]  clr_idx;
    logic              set_en;
    logic              clr_en;

    //////////////////////////////////////////////////////////////////////
    // Set and clear
    //////////////////////////////////////////////////////////////////////
    assign set_idx = {load_issue_hart, load_issue_rd};
    assign set_en  = load_issue && (load_issue_rd != '0);   // x0 never waits

    // Only a load result releases the register
    assign clr_idx = {commit.wr.hart, commit.wr.addr};
    assign clr_en  = commit.wr.valid && (commit.src == SRC_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (clr_en) begin
                busy[clr_idx] <= 1'b0;
            end
            if (set_en) begin
                busy[set_idx] <= 1'b1;  // Later assignment, set wins
            end
        end
    end

    // Busy lookup straight from stored bits
    assign rs1_busy = busy[{rd_hart, rs1_addr}];
    assign rs2_busy = busy[{rd_hart, rs2_addr}];

endmodule

// File: design/wb_arbiter.sv
// Write-port arbiter for ALU and load writeback with a two-entry load holding queue
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  gpr_pkg::gpr_write_t  alu_wr,     // Fixed priority writer
    input  gpr_pkg::gpr_write_t  load_wr,    // Late load result
    output gpr_pkg::gpr_commit_t commit,     // One granted write per cycle
    output logic                 load_full   // Queue holds two entries
);

    import gpr_pkg::*;

    localparam int Q_DEPTH = 2;

    //////////////////////////////////////////////////////////////////////
    // Holding queue state
    //////////////////////////////////////////////////////////////////////
    gpr_write_t  q_mem [Q_DEPTH];   // Losing loads, oldest at q_rd_ptr
    logic        q_wr_ptr;          // Tail slot
    logic        q_rd_ptr;          // Head slot
    logic [1:0]  q_count;           // 0..2 entries

    logic        q_empty;
    logic        q_pop;             // Head granted this cycle
    logic        q_push;            // New load parked this cycle
    logic        load_direct;       // New load granted straight through

    assign q_empty   = (q_count == '0);
    assign load_full = (q_count == 2'(Q_DEPTH));

    //////////////////////////////////////////////////////////////////////
    // Grant
    //////////////////////////////////////////////////////////////////////

    // ALU first, then oldest queued load, then a fresh load
    always_comb begin
        commit      = '0;
        q_pop       = 1'b0;
        load_direct = 1'b0;
        if (alu_wr.valid) begin
            commit.wr  = alu_wr;
            commit.src = SRC_ALU;
        end else if (!q_empty) begin
            commit.wr  = q_mem[q_rd_ptr];
            commit.src = SRC_LOAD;
            q_pop      = 1'b1;          // Drain one per idle ALU cycle
        end else if (load_wr.valid) begin
            commit.wr   = load_wr;
            commit.src  = SRC_LOAD;
            load_direct = 1'b1;
        end
    end

    // A loser joins the tail; load presented while full is dropped
    assign q_push = load_wr.valid && !load_direct && !load_full;

    //////////////////////////////////////////////////////////////////////
    // Queue update
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= 1'b0;
            q_rd_ptr <= 1'b0;
            q_count  <= '0;
        end else begin
            if (q_push) begin
                q_wr_ptr <= ~q_wr_ptr;
            end
            if (q_pop) begin
                q_rd_ptr <= ~q_rd_ptr;
            end
            case ({q_push, q_pop})
                2'b10:   q_count <= q_count + 2'd1;
                2'b01:   q_count <= q_count - 2'd1;
                default: q_count <= q_count;    // Both or neither
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (q_push) begin
            q_mem[q_wr_ptr] <= load_wr;
        end
    end

endmodule

// File: design/gpr_bank.sv
// Multi-hart register array, two bypassed read ports, one write port
`timescale 1ns/1ps

module gpr_bank #(
    parameter int NUM_HARTS = 4                 // Harts sharing the array
) (
    input  logic                clk,
    input  logic                rst,
    input  gpr_pkg::gpr_commit_t commit,        // Granted write from the arbiter
    input  gpr_pkg::hart_id_t   rd_hart,        // Hart being decoded
    input  gpr_pkg::reg_addr_t  rs1_addr,
    input  gpr_pkg::reg_addr_t  rs2_addr,
    output gpr_pkg::word_t      rs1_data,
    output gpr_pkg::word_t      rs2_data
);

    import gpr_pkg::*;

    localparam int IDX_W = HART_ID_W + REG_ADDR_W;     // {hart, reg} index
    localparam int DEPTH = NUM_HARTS * REGS_PER_HART;  // Physical words

    word_t             regs [DEPTH];    // Register storage for all harts
    logic              rs1_hit;         // Commit matches port 0 operand
    logic              rs2_hit;         // Commit matches port 1 operand
    logic [IDX_W-1:0]  wr_idx;          // Flat write index
    logic              wr_en;           // Qualified write

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    // Bypass match on the writer's hart and register
    assign rs1_hit = commit.wr.valid && (commit.wr.hart == rd_hart)
                  && (commit.wr.addr == rs1_addr);
    assign rs2_hit = commit.wr.valid && (commit.wr.hart == rd_hart)
                  && (commit.wr.addr == rs2_addr);

    // x0 forced to zero, then bypass, then array
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      rs1_hit          ? commit.wr.data :
                                         regs[{rd_hart, rs1_addr}];   // Port 0
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      rs2_hit          ? commit.wr.data :
                                         regs[{rd_hart, rs2_addr}];   // Port 1

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    // Index taken from the writer's hart, not the decode hart
    assign wr_idx = {commit.wr.hart, commit.wr.addr};
    assign wr_en  = commit.wr.valid && (commit.wr.addr != '0);  // Writes to x0 discarded

    always_ff @(posedge clk) begin
        if (!rst && wr_en) begin
            regs[wr_idx] <= commit.wr.data;
        end
    end

endmodule

// File: design/gpr_pkg.sv
// Widths, register and hart types, write record, writeback source and commit record
package gpr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN          = 32;              // Register data width
    localparam int REG_ADDR_W    = 5;               // Register number within a hart
    localparam int HART_ID_W     = 2;               // Covers up to 4 harts
    localparam int REGS_PER_HART = 1 << REG_ADDR_W; // 32 architectural registers

    //////////////////////////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////////////////////////
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // x0..x31
    typedef logic [XLEN-1:0]       word_t;      // Register contents
    typedef logic [HART_ID_W-1:0]  hart_id_t;   // Owning hart

    // One register write from a writeback source, 40 bits
    typedef struct packed {
        logic      valid;   // Write strobe
        hart_id_t  hart;    // Writer's own hart
        reg_addr_t addr;    // Destination register
        word_t     data;    // Result
    } gpr_write_t;

    // Which writer owns the granted write
    typedef enum logic {
        SRC_ALU  = 1'b0,
        SRC_LOAD = 1'b1
    } wb_src_e;

    // Granted write plus its source, 41 bits
    // Shared by the register bank and the load scoreboard
    typedef struct packed {
        gpr_write_t wr;
        wb_src_e    src;
    } gpr_commit_t;

endpackage
